// File: list.f
+incdir+rtl
+incdir+testbench
rtl/des_pkg.sv
rtl/logic_eval.sv
rtl/sync_fifo.sv
rtl/graph_mem.sv
rtl/des_core.sv
rtl/des_top.sv
testbench/des_tb.sv

// File: Bender.yml
package:
  name: des_engine

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/des_pkg.sv
      - rtl/logic_eval.sv
      - rtl/sync_fifo.sv
      - rtl/graph_mem.sv
      - rtl/des_core.sv
      - rtl/des_top.sv
  - target: test
    include_dirs:
      - rtl
      - testbench
    files:
      - testbench/des_tb.sv

// File: testbench/des_tb_table.svh
`ifndef DES_TB_TABLE_SVH
`define DES_TB_TABLE_SVH

localparam int N_STIM  = 18;
localparam int N_TASKS = 16;
localparam int N_UNDO  = 16;

// table bases as word indices in words 3 to 5
localparam logic [31:0] OFS_WORD  = 32'd16;
localparam logic [31:0] NBR_WORD  = 32'd48;
localparam logic [31:0] DATA_WORD = 32'd64; // records at byte 0x100 + 4*v

// vertex v owns neighbour words ofs[v] to ofs[v+1]-1 and v3 owns none
logic [31:0] ofs_tab [9] = '{32'd0, 32'd2, 32'd3, 32'd4, 32'd4, 32'd6, 32'd7, 32'd8, 32'd9};

// neighbour word is {locale, port}
logic [31:0] nbr_tab [9] = '{
   32'h0000_0002, 32'h0002_468b, 32'h0000_0006, 32'h0000_000e, 32'h0000_0007,
   32'h0000_000a, 32'h0000_000d, 32'h0000_0000, 32'h0000_0009
};

// record nibbles are 0, out, in0*4+in1, kind and a 16-bit delay
logic [31:0] rec_tab [8] = '{
   32'h0014_0005, // v0 and2
   32'h0145_0003, // v1 or2
   32'h0052_0002, // v2 nand2
   32'h0101_0007, // v3 inv
   32'h0103_0004, // v4 nor2
   32'h0116_0001, // v5 xor2
   32'h0157_0006, // v6 xnor2
   32'h0280_0009  // v7 buf with input at x
};

// ts, locale, port, level
des_pkg::task_t stim_tab [N_STIM] = '{
   '{32'd100, 31'd0, 1'b0, des_pkg::LOGIC_1}, // first task flips output 0 to 1
   '{32'd110, 31'd1, 1'b1, des_pkg::LOGIC_X}, // or2 held by 1 so input only
   '{32'd120, 31'd1, 1'b1, des_pkg::LOGIC_0}, // undo shows x written back
   '{32'd130, 31'd1, 1'b0, des_pkg::LOGIC_1}, // no change
   '{32'd140, 31'd3, 1'b0, des_pkg::LOGIC_1}, // zero fan-out
   '{32'd150, 31'd3, 1'b0, des_pkg::LOGIC_X},
   '{32'd160, 31'd2, 1'b1, des_pkg::LOGIC_Z}, // nand2(1,z) gives x
   '{32'd170, 31'd2, 1'b0, des_pkg::LOGIC_0}, // controlling 0 over z
   '{32'd180, 31'd4, 1'b1, des_pkg::LOGIC_X},
   '{32'd190, 31'd4, 1'b0, des_pkg::LOGIC_1}, // controlling 1 over x
   '{32'd200, 31'd5, 1'b0, des_pkg::LOGIC_Z},
   '{32'd210, 31'd6, 1'b1, des_pkg::LOGIC_0},
   '{32'd215, 31'd6, 1'b0, des_pkg::LOGIC_X}, // xnor2(x,0) gives x
   '{32'd220, 31'd7, 1'b0, des_pkg::LOGIC_Z}, // buf output stays x
   '{32'd230, 31'd7, 1'b0, des_pkg::LOGIC_0},
   '{32'd240, 31'd0, 1'b1, des_pkg::LOGIC_1}, // no change
   '{32'd250, 31'd0, 1'b1, des_pkg::LOGIC_X},
   '{32'd260, 31'd0, 1'b0, des_pkg::LOGIC_0}
};

des_pkg::task_t exp_tasks [N_TASKS] = '{
   '{32'd105, 31'd1,       1'b0, des_pkg::LOGIC_1},
   '{32'd105, 31'h12345,   1'b1, des_pkg::LOGIC_1},
   '{32'd162, 31'd7,       1'b0, des_pkg::LOGIC_X},
   '{32'd172, 31'd7,       1'b0, des_pkg::LOGIC_1},
   '{32'd184, 31'd3,       1'b1, des_pkg::LOGIC_X},
   '{32'd184, 31'd5,       1'b0, des_pkg::LOGIC_X},
   '{32'd194, 31'd3,       1'b1, des_pkg::LOGIC_0},
   '{32'd194, 31'd5,       1'b0, des_pkg::LOGIC_0},
   '{32'd201, 31'd6,       1'b1, des_pkg::LOGIC_X},
   '{32'd216, 31'd0,       1'b0, des_pkg::LOGIC_0},
   '{32'd221, 31'd0,       1'b0, des_pkg::LOGIC_X},
   '{32'd239, 31'd4,       1'b1, des_pkg::LOGIC_0},
   '{32'd255, 31'd1,       1'b0, des_pkg::LOGIC_X},
   '{32'd255, 31'h12345,   1'b1, des_pkg::LOGIC_X},
   '{32'd265, 31'd1,       1'b0, des_pkg::LOGIC_0},
   '{32'd265, 31'h12345,   1'b1, des_pkg::LOGIC_0}
};

// byte address and record before the update
des_pkg::undo_entry_t exp_undo [N_UNDO] = '{
   '{32'h0000_0100, 32'h0014_0005},
   '{32'h0000_0104, 32'h0145_0003},
   '{32'h0000_0104, 32'h0165_0003},
   '{32'h0000_010c, 32'h0101_0007},
   '{32'h0000_010c, 32'h0041_0007},
   '{32'h0000_0108, 32'h0052_0002},
   '{32'h0000_0108, 32'h0272_0002},
   '{32'h0000_0110, 32'h0103_0004},
   '{32'h0000_0110, 32'h0223_0004},
   '{32'h0000_0114, 32'h0116_0001},
   '{32'h0000_0118, 32'h0157_0006},
   '{32'h0000_0118, 32'h0047_0006},
   '{32'h0000_011c, 32'h0280_0009},
   '{32'h0000_011c, 32'h02c0_0009},
   '{32'h0000_0100, 32'h0154_0005},
   '{32'h0000_0100, 32'h0264_0005}
};

`endif

// File: testbench/des_tb.sv
`default_nettype none
`include "des_defs.svh"

module des_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int AW = $clog2(`DES_MEM_WORDS);

   `include "des_tb_table.svh"

   localparam int TIMEOUT_CYCLES = N_STIM * 200 + `DES_MEM_WORDS + 64;

   logic                 clk;
   logic                 rstn;
   des_pkg::task_t       task_in;
   logic                 task_in_valid;
   logic                 task_in_ready;
   des_pkg::task_t       task_out;
   logic                 task_out_valid;
   logic                 task_out_ready;
   des_pkg::undo_entry_t undo_out;
   logic                 undo_valid;
   logic                 undo_ready;
   logic                 load_valid;
   logic [AW-1:0]        load_addr;
   logic [31:0]          load_data;
   logic                 busy;
   logic [31:0]          mem_image [`DES_MEM_WORDS];
   int                   task_idx = 0;
   int                   undo_idx = 0;
   int                   cycles = 0;

   des_top dut_i (
      .clk (clk), .rstn (rstn),
      .task_in (task_in), .task_in_valid (task_in_valid), .task_in_ready (task_in_ready),
      .task_out (task_out), .task_out_valid (task_out_valid),
      .task_out_ready (task_out_ready),
      .undo_out (undo_out), .undo_valid (undo_valid), .undo_ready (undo_ready),
      .load_valid (load_valid), .load_addr (load_addr), .load_data (load_data),
      .busy (busy)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_task(input des_pkg::task_t got);
      if (task_idx >= N_TASKS) begin
         abort_run($sformatf("task_out delivered an extra task 0x%h", got));
      end else if (got !== exp_tasks[task_idx]) begin
         abort_run($sformatf("[ERROR] task_out #%0d: got 0x%h, expected 0x%h",
                             task_idx, got, exp_tasks[task_idx]));
      end else begin
         task_idx++;
      end
   endtask

   task automatic check_undo(input des_pkg::undo_entry_t got);
      if (undo_idx >= N_UNDO) begin
         abort_run($sformatf("undo_out delivered an extra entry 0x%h", got));
      end else if (got !== exp_undo[undo_idx]) begin
         abort_run($sformatf("[ERROR] undo_out #%0d: got 0x%h, expected 0x%h",
                             undo_idx, got, exp_undo[undo_idx]));
      end else begin
         undo_idx++;
      end
   endtask

   task automatic build_image();
      for (int w = 0; w < `DES_MEM_WORDS; w++) begin
         mem_image[w] = {8'hd5, 8'(w), ~8'(w), 8'(w)}; // filler, never read
      end
      mem_image[`DES_BASE_OFFSET_WORD]    = OFS_WORD;
      mem_image[`DES_BASE_NEIGHBORS_WORD] = NBR_WORD;
      mem_image[`DES_BASE_DATA_WORD]      = DATA_WORD;
      for (int k = 0; k < 9; k++) begin
         mem_image[OFS_WORD + k] = ofs_tab[k];
         mem_image[NBR_WORD + k] = nbr_tab[k];
      end
      for (int v = 0; v < 8; v++) begin
         mem_image[DATA_WORD + v] = rec_tab[v];
      end
   endtask

   task automatic load_memory();
      for (int w = 0; w < `DES_MEM_WORDS; w++) begin
         @(posedge clk);
         load_valid <= 1'b1;
         load_addr  <= AW'(w);
         load_data  <= mem_image[w];
      end
      @(posedge clk);
      load_valid <= 1'b0;
   endtask

   task automatic send_task(input des_pkg::task_t t);
      @(posedge clk);
      task_in       <= t;
      task_in_valid <= 1'b1;
      do begin
         @(posedge clk);
      end while (!task_in_ready);
      task_in_valid <= 1'b0;
   endtask

   task automatic wait_task_done();
      while (!busy) @(posedge clk); // core picks it up from the queue
      while (busy) @(posedge clk);
   endtask

   always @(posedge clk) begin
      if (rstn && task_out_valid && task_out_ready) begin
         check_task(task_out);
      end
      if (rstn && undo_valid && undo_ready) begin
         check_undo(undo_out);
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         abort_run($sformatf("timeout: the run did not finish within %0d cycles", cycles));
      end
   end

   // random back-pressure on both outputs
   initial begin
      task_out_ready = 1'b0;
      undo_ready     = 1'b0;
      void'($urandom(96));
      forever begin
         @(posedge clk);
         task_out_ready <= ($urandom % 4) != 0;
         undo_ready     <= ($urandom % 3) != 0;
      end
   end

   initial begin
      clk           = 1'b0;
      rstn          = 1'b0;
      task_in       = '0;
      task_in_valid = 1'b0;
      load_valid    = 1'b0;
      load_addr     = '0;
      load_data     = '0;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      build_image();
      load_memory();
      for (int s = 0; s < N_STIM; s++) begin
         send_task(stim_tab[s]);
         wait_task_done();
      end
      while ((task_idx < N_TASKS) || (undo_idx < N_UNDO)) @(posedge clk);
      repeat (20) @(posedge clk); // catch late extras
      if ((task_idx == N_TASKS) && (undo_idx == N_UNDO) && !busy) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         abort_run("outputs were missing or the core was still busy at the end");
      end
   end

endmodule

`default_nettype wire

// File: rtl/des_top.sv
`default_nettype none
`include "des_defs.svh"

module des_top (
   input  logic                              clk,
   input  logic                              rstn,
   input  des_pkg::task_t                    task_in,
   input  logic                              task_in_valid,
   output logic                              task_in_ready,
   output des_pkg::task_t                    task_out,
   output logic                              task_out_valid,
   input  logic                              task_out_ready,
   output des_pkg::undo_entry_t              undo_out,
   output logic                              undo_valid,
   input  logic                              undo_ready,
   input  logic                              load_valid,
   input  logic [$clog2(`DES_MEM_WORDS)-1:0] load_addr,
   input  logic [31:0]                       load_data,
   output logic                              busy
);

   des_pkg::task_t       q_task;
   logic                 q_task_valid;
   logic                 q_task_ready;
   des_pkg::task_t       c_task;
   logic                 c_task_valid;
   logic                 c_task_ready;
   des_pkg::undo_entry_t c_undo;
   logic                 c_undo_valid;
   logic                 c_undo_ready;
   des_pkg::mem_rd_req_t rd_req;
   logic                 rd_req_valid;
   logic                 rd_req_ready;
   des_pkg::mem_rd_rsp_t rd_rsp;
   logic                 rd_rsp_valid;
   logic                 rd_rsp_ready;
   des_pkg::mem_wr_req_t wr_req;
   logic                 wr_req_valid;
   logic                 wr_req_ready;
   logic                 wr_done;
   logic                 core_idle;

   assign busy = !core_idle;

   sync_fifo #(.payload_t(des_pkg::task_t), .DEPTH(`DES_TQ_DEPTH)) in_q_i (
      .clk (clk), .rstn (rstn),
      .in_data (task_in), .in_valid (task_in_valid), .in_ready (task_in_ready),
      .out_data (q_task), .out_valid (q_task_valid), .out_ready (q_task_ready)
   );

   sync_fifo #(.payload_t(des_pkg::task_t), .DEPTH(`DES_TQ_DEPTH)) out_q_i (
      .clk (clk), .rstn (rstn),
      .in_data (c_task), .in_valid (c_task_valid), .in_ready (c_task_ready),
      .out_data (task_out), .out_valid (task_out_valid), .out_ready (task_out_ready)
   );

   sync_fifo #(.payload_t(des_pkg::undo_entry_t), .DEPTH(`DES_UQ_DEPTH)) undo_q_i (
      .clk (clk), .rstn (rstn),
      .in_data (c_undo), .in_valid (c_undo_valid), .in_ready (c_undo_ready),
      .out_data (undo_out), .out_valid (undo_valid), .out_ready (undo_ready)
   );

   des_core core_i (
      .clk (clk), .rstn (rstn),
      .task_in (q_task), .task_in_valid (q_task_valid), .task_in_ready (q_task_ready),
      .task_out (c_task), .task_out_valid (c_task_valid), .task_out_ready (c_task_ready),
      .undo_out (c_undo), .undo_valid (c_undo_valid), .undo_ready (c_undo_ready),
      .rd_req (rd_req), .rd_req_valid (rd_req_valid), .rd_req_ready (rd_req_ready),
      .rd_rsp (rd_rsp), .rd_rsp_valid (rd_rsp_valid), .rd_rsp_ready (rd_rsp_ready),
      .wr_req (wr_req), .wr_req_valid (wr_req_valid), .wr_req_ready (wr_req_ready),
      .wr_done (wr_done), .idle (core_idle)
   );

   graph_mem mem_i (
      .clk (clk), .rstn (rstn),
      .rd_req (rd_req), .rd_req_valid (rd_req_valid), .rd_req_ready (rd_req_ready),
      .rd_rsp (rd_rsp), .rd_rsp_valid (rd_rsp_valid), .rd_rsp_ready (rd_rsp_ready),
      .wr_req (wr_req), .wr_req_valid (wr_req_valid), .wr_req_ready (wr_req_ready),
      .wr_done (wr_done),
      .load_valid (load_valid), .load_addr (load_addr), .load_data (load_data)
   );

endmodule

`default_nettype wire

// File: rtl/des_core.sv
`default_nettype none
`include "des_defs.svh"

module des_core (
   input  logic                 clk,
   input  logic                 rstn,
   input  des_pkg::task_t       task_in,
   input  logic                 task_in_valid,
   output logic                 task_in_ready,
   output des_pkg::task_t       task_out,
   output logic                 task_out_valid,
   input  logic                 task_out_ready,
   output des_pkg::undo_entry_t undo_out,
   output logic                 undo_valid,
   input  logic                 undo_ready,
   output des_pkg::mem_rd_req_t rd_req,
   output logic                 rd_req_valid,
   input  logic                 rd_req_ready,
   input  des_pkg::mem_rd_rsp_t rd_rsp,
   input  logic                 rd_rsp_valid,
   output logic                 rd_rsp_ready,
   output des_pkg::mem_wr_req_t wr_req,
   output logic                 wr_req_valid,
   input  logic                 wr_req_ready,
   input  logic                 wr_done,
   output logic                 idle
);

   localparam int AW = `DES_ADDR_W;
   localparam int TW = `DES_TS_W;

   typedef enum logic [3:0] {
      IDLE, BASE_REQ, BASE_WAIT, DATA_REQ, DATA_WAIT, EVAL,
      EDGE_REQ, EDGE_WAIT, NBR_REQ, NBR_WAIT, WAIT_WRITE
   } state_t;

   typedef enum logic [1:0] {W_IDLE, W_UNDO, W_WRITE, W_DONE} wstate_t;

   state_t              state;
   state_t              state_next;
   wstate_t             wstate;
   wstate_t             wstate_next;
   des_pkg::task_t      task_q;
   des_pkg::gate_rec_t  old_rec;
   des_pkg::gate_rec_t  new_rec;
   des_pkg::logic_val_t new_in0;
   des_pkg::logic_val_t new_in1;
   des_pkg::logic_val_t new_out;
   logic                initialized;
   logic                wr_begin;
   logic                out_changed;
   logic                in_changed;
   logic [31:0]         base_word;
   logic [AW-1:0]       base_off;
   logic [AW-1:0]       base_nbr;
   logic [AW-1:0]       base_data;
   logic [AW-1:0]       vid_ofs;
   logic [31:0]         edge_lo;
   logic [31:0]         edge_hi;

   assign idle          = (state == IDLE);
   assign task_in_ready = idle;
   assign vid_ofs       = AW'(task_q.locale) << 2; // vertex id times four

   assign new_in0 = task_q.port ? old_rec.in0 : task_q.val;
   assign new_in1 = task_q.port ? task_q.val : old_rec.in1;

   logic_eval eval_i (
      .p0   (new_in0),
      .p1   (new_in1),
      .gate (old_rec.kind),
      .o    (new_out)
   );

   assign out_changed = (new_out != old_rec.out_val);
   assign in_changed  = (new_in0 != old_rec.in0) || (new_in1 != old_rec.in1);

   always_comb begin
      new_rec         = old_rec;
      new_rec.out_val = new_out;
      new_rec.in0     = new_in0;
      new_rec.in1     = new_in1;
   end

   // one task per neighbour beat
   assign task_out_valid = (state == NBR_WAIT) && rd_rsp_valid;
   assign task_out = '{ts: task_q.ts + TW'(old_rec.delay), locale: rd_rsp.data[31:1],
                       port: rd_rsp.data[0], val: new_out};
   assign rd_rsp_ready = (state == BASE_WAIT) || (state == DATA_WAIT) ||
                         (state == EDGE_WAIT) || ((state == NBR_WAIT) && task_out_ready);

   always_comb begin
      state_next   = state;
      wr_begin     = 1'b0;
      rd_req_valid = 1'b0;
      rd_req.addr  = base_data + vid_ofs;
      rd_req.len   = 8'd0;
      case (state)
         IDLE: begin
            if (task_in_valid) begin
               state_next = initialized ? DATA_REQ : BASE_REQ;
            end
         end
         BASE_REQ: begin // all three pointers in one burst
            rd_req_valid = 1'b1;
            rd_req.addr  = `DES_BASE_OFFSET_WORD << 2;
            rd_req.len   = 8'(`DES_BASE_DATA_WORD - `DES_BASE_OFFSET_WORD);
            if (rd_req_ready) begin
               state_next = BASE_WAIT;
            end
         end
         BASE_WAIT: begin
            if (rd_rsp_valid && rd_rsp.last) begin
               state_next = DATA_REQ;
            end
         end
         DATA_REQ: begin
            rd_req_valid = 1'b1;
            if (rd_req_ready) begin
               state_next = DATA_WAIT;
            end
         end
         DATA_WAIT: begin
            if (rd_rsp_valid) begin
               state_next = EVAL;
            end
         end
         EVAL: begin
            if (out_changed) begin
               wr_begin   = 1'b1; // record write runs beside fan-out
               state_next = EDGE_REQ;
            end else if (in_changed) begin
               wr_begin   = 1'b1;
               state_next = WAIT_WRITE;
            end else begin
               state_next = IDLE;
            end
         end
         EDGE_REQ: begin
            rd_req_valid = 1'b1;
            rd_req.addr  = base_off + vid_ofs;
            rd_req.len   = 8'd1;
            if (rd_req_ready) begin
               state_next = EDGE_WAIT;
            end
         end
         EDGE_WAIT: begin
            if (rd_rsp_valid && rd_rsp.last) begin
               state_next = NBR_REQ;
            end
         end
         NBR_REQ: begin
            if (edge_lo == edge_hi) begin
               state_next = WAIT_WRITE; // no fan-out
            end else begin
               rd_req_valid = 1'b1;
               rd_req.addr  = base_nbr + (edge_lo << 2);
               rd_req.len   = 8'(edge_hi - edge_lo - 32'd1);
               if (rd_req_ready) begin
                  state_next = NBR_WAIT;
               end
            end
         end
         NBR_WAIT: begin
            if (rd_rsp_valid && task_out_ready && rd_rsp.last) begin
               state_next = WAIT_WRITE;
            end
         end
         WAIT_WRITE: begin
            if (wstate == W_IDLE) begin
               state_next = IDLE;
            end
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   // undo entry first, then the record write
   assign undo_valid   = (wstate == W_UNDO);
   assign undo_out     = '{addr: base_data + vid_ofs, rec: old_rec};
   assign wr_req_valid = (wstate == W_WRITE);
   assign wr_req       = '{addr: base_data + vid_ofs, data: new_rec};

   always_comb begin
      wstate_next = wstate;
      case (wstate)
         W_IDLE:  wstate_next = wr_begin ? W_UNDO : W_IDLE;
         W_UNDO:  wstate_next = undo_ready ? W_WRITE : W_UNDO;
         W_WRITE: wstate_next = wr_req_ready ? W_DONE : W_WRITE;
         default: wstate_next = wr_done ? W_IDLE : W_DONE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state       <= IDLE;
         wstate      <= W_IDLE;
         initialized <= 1'b0;
      end else begin
         state  <= state_next;
         wstate <= wstate_next;
         if (state == BASE_REQ) begin
            initialized <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (idle && task_in_valid) begin
         task_q <= task_in;
      end
      if (state == BASE_REQ) begin
         base_word <= `DES_BASE_OFFSET_WORD;
      end
      if ((state == BASE_WAIT) && rd_rsp_valid) begin
         base_word <= base_word + 32'd1;
         case (base_word) // pointers are word indices
            `DES_BASE_OFFSET_WORD:    base_off  <= {rd_rsp.data[AW-3:0], 2'b00};
            `DES_BASE_NEIGHBORS_WORD: base_nbr  <= {rd_rsp.data[AW-3:0], 2'b00};
            `DES_BASE_DATA_WORD:      base_data <= {rd_rsp.data[AW-3:0], 2'b00};
            default: ;
         endcase
      end
      if ((state == DATA_WAIT) && rd_rsp_valid) begin
         old_rec <= des_pkg::gate_rec_t'(rd_rsp.data);
      end
      if ((state == EDGE_WAIT) && rd_rsp_valid) begin
         if (rd_rsp.last) begin
            edge_hi <= rd_rsp.data;
         end else begin
            edge_lo <= rd_rsp.data;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/graph_mem.sv
`default_nettype none
`include "des_defs.svh"

module graph_mem (
   input  logic                                clk,
   input  logic                                rstn,
   input  des_pkg::mem_rd_req_t                rd_req,
   input  logic                                rd_req_valid,
   output logic                                rd_req_ready,
   output des_pkg::mem_rd_rsp_t                rd_rsp,
   output logic                                rd_rsp_valid,
   input  logic                                rd_rsp_ready,
   input  des_pkg::mem_wr_req_t                wr_req,
   input  logic                                wr_req_valid,
   output logic                                wr_req_ready,
   output logic                                wr_done,
   input  logic                                load_valid,
   input  logic [$clog2(`DES_MEM_WORDS)-1:0]   load_addr,
   input  logic [31:0]                         load_data
);

   localparam int AW = $clog2(`DES_MEM_WORDS);

   logic [31:0]   words [`DES_MEM_WORDS];
   logic          bursting;
   logic [7:0]    beats_left;
   logic [AW-1:0] rd_word;
   logic          rd_start;
   logic          beat_taken;

   assign rd_req_ready = !bursting;
   assign wr_req_ready = !bursting;
   assign rd_rsp_valid = bursting;
   assign rd_rsp       = '{data: words[rd_word], last: (beats_left == 8'd0)};
   assign rd_start     = rd_req_valid && rd_req_ready;
   assign beat_taken   = rd_rsp_valid && rd_rsp_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         bursting <= 1'b0;
         wr_done  <= 1'b0;
      end else begin
         wr_done <= wr_req_valid && wr_req_ready; // one cycle after accept
         if (rd_start) begin
            bursting <= 1'b1;
         end else if (beat_taken && rd_rsp.last) begin
            bursting <= 1'b0;
         end
      end
   end

   // address and beat counters
   always_ff @(posedge clk) begin
      if (rd_start) begin
         rd_word    <= rd_req.addr[AW+1:2];
         beats_left <= rd_req.len;
      end else if (beat_taken) begin
         rd_word    <= rd_word + 1'b1;
         beats_left <= beats_left - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_req_valid && wr_req_ready) begin
         words[wr_req.addr[AW+1:2]] <= wr_req.data; // byte address to word
      end
      if (load_valid) begin
         words[load_addr] <= load_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
`default_nettype none

module sync_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     rstn,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t      slots [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;
   logic          push;
   logic          pop;

   assign in_ready  = (count != (PW+1)'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = slots[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + (PW+1)'(push) - (PW+1)'(pop); // push and pop may overlap
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         slots[wr_ptr] <= in_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/logic_eval.sv
`default_nettype none

module logic_eval (
   input  des_pkg::logic_val_t p0,
   input  des_pkg::logic_val_t p1,
   input  des_pkg::gate_t      gate,
   output des_pkg::logic_val_t o
);

   des_pkg::logic_val_t a;
   des_pkg::logic_val_t b;
   des_pkg::logic_val_t r;
   logic any_x;
   logic any_0;
   logic any_1;
   logic invert;

   always_comb begin
      a = (p0 == des_pkg::LOGIC_Z) ? des_pkg::LOGIC_X : p0; // z reads as x
      b = (p1 == des_pkg::LOGIC_Z) ? des_pkg::LOGIC_X : p1;
      any_x = (a == des_pkg::LOGIC_X) || (b == des_pkg::LOGIC_X);
      any_0 = (a == des_pkg::LOGIC_0) || (b == des_pkg::LOGIC_0);
      any_1 = (a == des_pkg::LOGIC_1) || (b == des_pkg::LOGIC_1);
      invert = gate inside {des_pkg::INV, des_pkg::NAND2, des_pkg::NOR2, des_pkg::XNOR2};
      case (gate)
         des_pkg::BUF, des_pkg::INV: begin
            r = a;
         end
         des_pkg::AND2, des_pkg::NAND2: begin
            r = any_0 ? des_pkg::LOGIC_0 : (any_x ? des_pkg::LOGIC_X : des_pkg::LOGIC_1);
         end
         des_pkg::OR2, des_pkg::NOR2: begin
            r = any_1 ? des_pkg::LOGIC_1 : (any_x ? des_pkg::LOGIC_X : des_pkg::LOGIC_0);
         end
         default: begin // xor family, no controlling value
            r = any_x ? des_pkg::LOGIC_X : ((a != b) ? des_pkg::LOGIC_1 : des_pkg::LOGIC_0);
         end
      endcase
      o = r;
      if (invert && (r != des_pkg::LOGIC_X)) begin
         o = (r == des_pkg::LOGIC_1) ? des_pkg::LOGIC_0 : des_pkg::LOGIC_1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/des_pkg.sv
`default_nettype none
`include "des_defs.svh"

package des_pkg;

   typedef enum logic [1:0] {
      LOGIC_0 = 2'd0,
      LOGIC_1 = 2'd1,
      LOGIC_X = 2'd2,
      LOGIC_Z = 2'd3
   } logic_val_t;

   typedef enum logic [2:0] {
      BUF   = 3'd0,
      INV   = 3'd1,
      NAND2 = 3'd2,
      NOR2  = 3'd3,
      AND2  = 3'd4,
      OR2   = 3'd5,
      XOR2  = 3'd6,
      XNOR2 = 3'd7
   } gate_t;

   typedef struct packed {
      logic [`DES_TS_W-1:0] ts;
      logic [30:0]          locale; // vertex id
      logic                 port;   // gate input that changes
      logic_val_t           val;
   } task_t;

   // memory image of one gate
   typedef struct packed {
      logic [5:0]  spare_hi;
      logic_val_t  out_val;
      logic_val_t  in0;
      logic_val_t  in1;
      logic        spare_lo;
      gate_t       kind;
      logic [15:0] delay;
   } gate_rec_t;

   typedef struct packed {
      logic [`DES_ADDR_W-1:0] addr;
      gate_rec_t              rec;  // record before the update
   } undo_entry_t;

   typedef struct packed {
      logic [`DES_ADDR_W-1:0] addr;
      logic [7:0]             len;  // beats minus one
   } mem_rd_req_t;

   typedef struct packed {
      logic [31:0] data;
      logic        last;
   } mem_rd_rsp_t;

   typedef struct packed {
      logic [`DES_ADDR_W-1:0] addr;
      logic [31:0]            data;
   } mem_wr_req_t;

endpackage

`default_nettype wire

// File: rtl/des_defs.svh
`ifndef DES_DEFS_SVH
`define DES_DEFS_SVH

// graph memory depth in 32-bit words
`define DES_MEM_WORDS 256

// byte address and timestamp widths
`define DES_ADDR_W 32
`define DES_TS_W 32

// queue depths
`define DES_TQ_DEPTH 8
`define DES_UQ_DEPTH 4

// word indices of the three table base pointers
`define DES_BASE_OFFSET_WORD 32'd3
`define DES_BASE_NEIGHBORS_WORD 32'd4
`define DES_BASE_DATA_WORD 32'd5

`endif
